/* Bender.yml */
package:
  name: super6502_mem

sources:
  - files:
      - rtl/super6502_mem_pkg.sv
      - rtl/bus_bridge.sv
      - rtl/byte_ram.sv
      - rtl/boot_rom.sv
      - rtl/response_merge.sv
      - rtl/super6502_mem.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/super6502_mem_tb.sv

/* boot_rom.mem */
a2
ff
9a
d8
a9
00
85
10
a9
f0
85
11
ea
ea
4c
0c
f0
00
40
58
60
18
69
01
38
e9
02
c9
80
d0
fa
5e

/* rtl/boot_rom.sv */
`timescale 1ns/1ns
`default_nettype none

module boot_rom (
    input   logic                                       i_sysclk,
    input   logic                                       i_rst,

    input   logic                                       i_strobe,
    input   logic [super6502_mem_pkg::ROM_ADDR_BITS-1:0] i_index,
    input   logic                                       i_write,

    output  logic                                       o_done,
    output  logic [super6502_mem_pkg::DATA_W-1:0]       o_rdata,
    output  super6502_mem_pkg::resp_t                   o_resp
);

import super6502_mem_pkg::*;

localparam int DEPTH = 1 << ROM_ADDR_BITS;

logic [DATA_W-1:0] mem [DEPTH];

logic [DATA_W-1:0] rd_q;
logic s1_valid;
logic s1_write;

integer i;

// anything past the hex image reads as zero
initial begin
    for (i = 0; i < DEPTH; i = i + 1) begin
        mem[i] = '0;
    end
    $readmemh("boot_rom.mem", mem);
end

// stage 1, array read
always_ff @(posedge i_sysclk) begin
    if (i_strobe) begin
        rd_q     <= mem[i_index];
        s1_write <= i_write;
    end
end

// stage 2, output register
always_ff @(posedge i_sysclk) begin
    if (s1_valid) begin
        o_rdata <= s1_write ? '0 : rd_q;
        o_resp  <= s1_write ? RESP_SLVERR : RESP_OKAY;  // array is never written
    end
end

always_ff @(posedge i_sysclk) begin
    if (i_rst) begin
        s1_valid <= 1'b0;
        o_done   <= 1'b0;
    end else begin
        s1_valid <= i_strobe;
        o_done   <= s1_valid;
    end
end

endmodule

`default_nettype wire

/* rtl/bus_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_bridge (
    input   logic                                       i_sysclk,
    input   logic                                       i_rst,

    input   logic                                       i_req_valid,
    output  logic                                       o_req_ready,
    input   logic [super6502_mem_pkg::ADDR_W-1:0]       i_req_addr,
    input   logic                                       i_req_write,
    input   logic [super6502_mem_pkg::DATA_W-1:0]       i_req_wdata,

    output  logic                                       o_ram_strobe,
    output  logic                                       o_rom_strobe,
    output  logic                                       o_dec_err,
    output  logic [super6502_mem_pkg::ROM_ADDR_BITS-1:0] o_index,
    output  logic                                       o_write,
    output  logic [super6502_mem_pkg::DATA_W-1:0]       o_wdata,

    input   logic                                       i_rsp_accepted
);

import super6502_mem_pkg::*;

bridge_state_t state;

logic accept;
logic hit_ram;
logic hit_rom;
logic dec_pend;
logic [ADDR_W-1:0] ram_off;
logic [ADDR_W-1:0] rom_off;

assign o_req_ready = (state == BR_IDLE);
assign accept = i_req_valid & o_req_ready;

assign hit_ram = (i_req_addr >= RAM_BASE) && (i_req_addr <= RAM_LAST);
assign hit_rom = (i_req_addr >= ROM_BASE) && (i_req_addr <= ROM_LAST);

assign ram_off = i_req_addr - RAM_BASE;
assign rom_off = i_req_addr - ROM_BASE;

always_ff @(posedge i_sysclk) begin
    if (i_rst) begin
        state        <= BR_IDLE;
        o_ram_strobe <= 1'b0;
        o_rom_strobe <= 1'b0;
        dec_pend     <= 1'b0;
        o_dec_err    <= 1'b0;
    end else begin
        o_ram_strobe <= accept & hit_ram;
        o_rom_strobe <= accept & hit_rom;
        dec_pend     <= accept & ~hit_ram & ~hit_rom;
        o_dec_err    <= dec_pend;   // lines up with a ram done pulse

        case (state)
            BR_IDLE: begin
                if (accept) begin
                    state <= BR_BUSY;
                end
            end
            BR_BUSY: begin
                if (i_rsp_accepted) begin
                    state <= BR_IDLE;
                end
            end
            default: state <= BR_IDLE;
        endcase
    end
end

// offset inside the matched window
always_ff @(posedge i_sysclk) begin
    if (accept) begin
        if (hit_rom) begin
            o_index <= rom_off[ROM_ADDR_BITS-1:0];
        end else begin
            o_index <= {{(ROM_ADDR_BITS-RAM_ADDR_BITS){1'b0}}, ram_off[RAM_ADDR_BITS-1:0]};
        end
        o_write <= i_req_write;
        o_wdata <= i_req_wdata;
    end
end

endmodule

`default_nettype wire

/* rtl/byte_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module byte_ram (
    input   logic                                       i_sysclk,
    input   logic                                       i_rst,

    input   logic                                       i_strobe,
    input   logic [super6502_mem_pkg::RAM_ADDR_BITS-1:0] i_index,
    input   logic                                       i_write,
    input   logic [super6502_mem_pkg::DATA_W-1:0]       i_wdata,

    output  logic                                       o_done,
    output  logic [super6502_mem_pkg::DATA_W-1:0]       o_rdata,
    output  super6502_mem_pkg::resp_t                   o_resp
);

import super6502_mem_pkg::*;

localparam int DEPTH = 1 << RAM_ADDR_BITS;

logic [DATA_W-1:0] mem [DEPTH];

integer i;

initial begin
    for (i = 0; i < DEPTH; i = i + 1) begin
        mem[i] = '0;
    end
end

always @(posedge i_sysclk) begin
    if (i_strobe && i_write) begin
        mem[i_index] <= i_wdata;
    end
end

// read data, writes answer with zero
always_ff @(posedge i_sysclk) begin
    if (i_strobe) begin
        o_rdata <= i_write ? '0 : mem[i_index];
    end
end

always_ff @(posedge i_sysclk) begin
    if (i_rst) begin
        o_done <= 1'b0;
    end else begin
        o_done <= i_strobe;
    end
end

assign o_resp = RESP_OKAY;  // ram never refuses an access

endmodule

`default_nettype wire

/* rtl/response_merge.sv */
`timescale 1ns/1ns
`default_nettype none

module response_merge (
    input   logic                                   i_sysclk,
    input   logic                                   i_rsp_ready,
    input   logic                                   i_rst,

    input   logic                                   i_ram_done,
    input   logic [super6502_mem_pkg::DATA_W-1:0]   i_ram_rdata,
    input   super6502_mem_pkg::resp_t               i_ram_resp,

    input   logic                                   i_rom_done,
    input   logic [super6502_mem_pkg::DATA_W-1:0]   i_rom_rdata,
    input   super6502_mem_pkg::resp_t               i_rom_resp,

    input   logic                                   i_dec_err,

    output  logic                                   o_rsp_valid,
    output  logic [super6502_mem_pkg::DATA_W-1:0]   o_rsp_rdata,
    output  super6502_mem_pkg::resp_t               o_rsp_resp,
    output  logic                                   o_rsp_accepted
);

import super6502_mem_pkg::*;

logic capture;

// only one source can finish at a time, bridge keeps one request in flight
assign capture = i_ram_done | i_rom_done | i_dec_err;

assign o_rsp_accepted = o_rsp_valid & i_rsp_ready;

always_ff @(posedge i_sysclk) begin
    if (i_rst) begin
        o_rsp_valid <= 1'b0;
    end else if (capture) begin
        o_rsp_valid <= 1'b1;
    end else if (o_rsp_accepted) begin
        o_rsp_valid <= 1'b0;
    end
end

// held until the response transfers
always_ff @(posedge i_sysclk) begin
    if (i_ram_done) begin
        o_rsp_rdata <= i_ram_rdata;
        o_rsp_resp  <= i_ram_resp;
    end else if (i_rom_done) begin
        o_rsp_rdata <= i_rom_rdata;
        o_rsp_resp  <= i_rom_resp;
    end else if (i_dec_err) begin
        o_rsp_rdata <= '0;
        o_rsp_resp  <= RESP_DECERR;
    end
end

endmodule

`default_nettype wire

/* rtl/super6502_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module super6502_mem (
    input   logic                                   i_sysclk,   // controller clock
    input   logic                                   i_rst,

    input   logic                                   i_req_valid,
    output  logic                                   o_req_ready,
    input   logic [super6502_mem_pkg::ADDR_W-1:0]   i_req_addr,
    input   logic                                   i_req_write,
    input   logic [super6502_mem_pkg::DATA_W-1:0]   i_req_wdata,

    output  logic                                   o_rsp_valid,
    input   logic                                   i_rsp_ready,
    output  logic [super6502_mem_pkg::DATA_W-1:0]   o_rsp_rdata,
    output  super6502_mem_pkg::resp_t               o_rsp_resp
);

import super6502_mem_pkg::*;

logic                       ram_strobe;
logic                       rom_strobe;
logic                       dec_err;
logic [ROM_ADDR_BITS-1:0]   index;
logic                       write;
logic [DATA_W-1:0]          wdata;
logic                       rsp_accepted;

logic                       ram_done;
logic [DATA_W-1:0]          ram_rdata;
resp_t                      ram_resp;
logic                       rom_done;
logic [DATA_W-1:0]          rom_rdata;
resp_t                      rom_resp;

bus_bridge u_bridge (
    .i_sysclk       (i_sysclk),
    .i_rst          (i_rst),
    .i_req_valid    (i_req_valid),
    .o_req_ready    (o_req_ready),
    .i_req_addr     (i_req_addr),
    .i_req_write    (i_req_write),
    .i_req_wdata    (i_req_wdata),
    .o_ram_strobe   (ram_strobe),
    .o_rom_strobe   (rom_strobe),
    .o_dec_err      (dec_err),
    .o_index        (index),
    .o_write        (write),
    .o_wdata        (wdata),
    .i_rsp_accepted (rsp_accepted)
);

byte_ram u_ram (
    .i_sysclk   (i_sysclk),
    .i_rst      (i_rst),
    .i_strobe   (ram_strobe),
    .i_index    (index[RAM_ADDR_BITS-1:0]),   // ram window is the low 512 bytes
    .i_write    (write),
    .i_wdata    (wdata),
    .o_done     (ram_done),
    .o_rdata    (ram_rdata),
    .o_resp     (ram_resp)
);

boot_rom u_rom (
    .i_sysclk   (i_sysclk),
    .i_rst      (i_rst),
    .i_strobe   (rom_strobe),
    .i_index    (index),
    .i_write    (write),
    .o_done     (rom_done),
    .o_rdata    (rom_rdata),
    .o_resp     (rom_resp)
);

response_merge u_merge (
    .i_sysclk       (i_sysclk),
    .i_rsp_ready    (i_rsp_ready),
    .i_rst          (i_rst),
    .i_ram_done     (ram_done),
    .i_ram_rdata    (ram_rdata),
    .i_ram_resp     (ram_resp),
    .i_rom_done     (rom_done),
    .i_rom_rdata    (rom_rdata),
    .i_rom_resp     (rom_resp),
    .i_dec_err      (dec_err),
    .o_rsp_valid    (o_rsp_valid),
    .o_rsp_rdata    (o_rsp_rdata),
    .o_rsp_resp     (o_rsp_resp),
    .o_rsp_accepted (rsp_accepted)
);

endmodule

`default_nettype wire

/* rtl/super6502_mem_pkg.sv */
`default_nettype none

package super6502_mem_pkg;

    // processor side bus
    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    // on-chip memory map, same windows as the crossbar on the full board
    localparam logic [ADDR_W-1:0] RAM_BASE = 16'h0000;
    localparam logic [ADDR_W-1:0] RAM_LAST = 16'h01ff;
    localparam logic [ADDR_W-1:0] ROM_BASE = 16'hf000;
    localparam logic [ADDR_W-1:0] ROM_LAST = 16'hffff;

    localparam int RAM_ADDR_BITS = 9;   // 512 bytes
    localparam int ROM_ADDR_BITS = 12;  // 4 KiB

    // axi style response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } resp_t;

    typedef enum logic {
        BR_IDLE = 1'b0,
        BR_BUSY = 1'b1
    } bridge_state_t;

endpackage

`default_nettype wire

/* sim.f */
rtl/super6502_mem_pkg.sv
rtl/bus_bridge.sv
rtl/byte_ram.sv
rtl/boot_rom.sv
rtl/response_merge.sv
rtl/super6502_mem.sv
testbench/tb_clock.sv
testbench/super6502_mem_tb.sv

/* testbench/super6502_mem_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module super6502_mem_tb;

import super6502_mem_pkg::*;

localparam int PERIOD       = 100;
localparam int RST_CYCLES   = 10;
localparam int DRIVE_DLY    = 10;   // inputs change this long after the rising edge
localparam int CYC_PER_TEST = 64;

logic       clk;
logic       rst;
logic       req_valid;
logic       req_ready;
logic [15:0] req_addr;
logic       req_write;
logic [7:0] req_wdata;
logic       rsp_valid;
logic       rsp_ready;
logic [7:0] rsp_rdata;
resp_t      rsp_resp;

// test list with one entry per data line
string       names[$];
logic        is_wr[$];
logic [15:0] addrs[$];
logic [7:0]  wdatas[$];
logic [7:0]  exp_rdatas[$];
logic [1:0]  exp_resps[$];

int     n_tests;
bit     loaded;
integer seed;

tb_clock #(.PERIOD(PERIOD)) clock_inst (.o_clk(clk));

super6502_mem super6502_mem_inst (
    .i_sysclk    (clk),
    .i_rst       (rst),
    .i_req_valid (req_valid),
    .o_req_ready (req_ready),
    .i_req_addr  (req_addr),
    .i_req_write (req_write),
    .i_req_wdata (req_wdata),
    .o_rsp_valid (rsp_valid),
    .i_rsp_ready (rsp_ready),
    .o_rsp_rdata (rsp_rdata),
    .o_rsp_resp  (rsp_resp)
);

task automatic report_failure(string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
endtask

task automatic check_value(string test, string what, int expected, int actual);
    assert (expected == actual) else begin
        $display("error %s %s: expected %0h actual %0h", test, what, expected, actual);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    end
endtask

task automatic load_tests();
    int          fd;
    int          r;
    int          c;
    string       tok;
    string       op;
    logic [15:0] a;
    logic [7:0]  wd;
    logic [7:0]  rd;
    logic [1:0]  rs;
    fd = $fopen("testbench/super6502_mem_testdata.txt", "r");
    assert (fd != 0) else report_failure("could not open the test data file");
    while (!$feof(fd)) begin
        r = $fscanf(fd, "%s", tok);
        if (r == 1 && tok[0] == "#") begin
            c = 0;
            while (c != "\n" && c != -1) begin   // skip the rest of a comment line
                c = $fgetc(fd);
            end
        end else if (r == 1) begin
            r = $fscanf(fd, "%s %h %h %h %h", op, a, wd, rd, rs);
            assert (r == 5) else report_failure("malformed line in the test data file");
            names.push_back(tok);
            is_wr.push_back(op == "wr");
            addrs.push_back(a);
            wdatas.push_back(wd);
            exp_rdatas.push_back(rd);
            exp_resps.push_back(rs);
        end
    end
    $fclose(fd);
    n_tests = names.size();
    loaded  = 1'b1;
endtask

// ends the run if responses stop coming
initial begin
    wait (loaded);
    #((n_tests * CYC_PER_TEST + RST_CYCLES + 4) * PERIOD);
    $display("timeout, the DUT stopped responding before the test list was done");
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
end

initial begin
    int         req_idx;
    int         rsp_idx;
    int         cyc;
    int         acc_cyc;
    bit         pending;
    bit         seen_valid;
    bit         req_fire;
    bit         rsp_fire;
    bit         prev_valid;
    bit         prev_ready;
    logic [7:0] prev_rdata;
    logic [1:0] prev_resp;
    req_valid  = 1'b0;
    req_addr   = '0;
    req_write  = 1'b0;
    req_wdata  = '0;
    rsp_ready  = 1'b0;
    rst        = 1'b1;
    loaded     = 1'b0;
    seed       = 32'hfe85_64b2;
    req_idx    = 0;
    rsp_idx    = 0;
    cyc        = 0;
    acc_cyc    = 0;
    pending    = 1'b0;
    seen_valid = 1'b0;
    prev_valid = 1'b0;
    prev_ready = 1'b0;
    prev_rdata = '0;
    prev_resp  = '0;
    load_tests();

    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DLY rst = 1'b0;

    while (rsp_idx < n_tests) begin
        @(posedge clk);
        cyc++;
        req_fire = req_valid && req_ready;
        rsp_fire = rsp_valid && rsp_ready;

        // exactly one transaction in flight
        if (pending) begin
            assert (!req_ready) else report_failure("request ready while a response is pending");
        end else begin
            assert (req_ready && !rsp_valid)
                else report_failure("DUT not idle with nothing in flight");
        end

        if (prev_valid && !prev_ready) begin
            assert (rsp_valid && rsp_rdata == prev_rdata && rsp_resp == prev_resp)
                else report_failure("response changed while held by back-pressure");
        end

        if (pending && rsp_valid && !seen_valid) begin
            seen_valid = 1'b1;
            check_value(names[rsp_idx], "latency", (addrs[rsp_idx] >= 16'hf000) ? 3 : 2,
                        cyc - acc_cyc - 1);
        end

        if (rsp_fire) begin
            check_value(names[rsp_idx], "rdata", exp_rdatas[rsp_idx], rsp_rdata);
            check_value(names[rsp_idx], "resp", exp_resps[rsp_idx], rsp_resp);
            rsp_idx++;
            pending = 1'b0;
        end
        if (req_fire) begin
            req_idx++;
            pending    = 1'b1;
            seen_valid = 1'b0;
            acc_cyc    = cyc;
        end

        prev_valid = rsp_valid;
        prev_ready = rsp_ready;
        prev_rdata = rsp_rdata;
        prev_resp  = rsp_resp;

        #DRIVE_DLY;
        if (req_idx < n_tests) begin
            req_valid = 1'b1;   // next request waits while the bridge is busy
            req_addr  = addrs[req_idx];
            req_write = is_wr[req_idx];
            req_wdata = wdatas[req_idx];
        end else begin
            req_valid = 1'b0;
        end
        rsp_ready = (($random(seed) & 3) != 0);
    end

    $display("TB PASSED");
    $finish;
end

endmodule

`default_nettype wire

/* testbench/super6502_mem_testdata.txt */
# name op(rd/wr) addr wdata exp_rdata exp_resp (0 okay, 2 slverr, 3 decerr)
ram_fresh_0000   rd 0000 00 00 0
ram_fresh_0123   rd 0123 00 00 0
ram_fresh_01ff   rd 01ff 00 00 0
ram_wr_0010      wr 0010 a5 00 0
ram_wr_0011      wr 0011 3c 00 0
ram_wr_000f      wr 000f 77 00 0
ram_rd_0010      rd 0010 00 a5 0
ram_rd_0011      rd 0011 00 3c 0
ram_rd_000f      rd 000f 00 77 0
ram_wr_01ff      wr 01ff e1 00 0
ram_rd_01ff      rd 01ff 00 e1 0
ram_rewr_0010    wr 0010 5a 00 0
ram_rerd_0010    rd 0010 00 5a 0
rom_rd_f000      rd f000 00 a2 0
rom_rd_f001      rd f001 00 ff 0
rom_rd_f002      rd f002 00 9a 0
rom_rd_f003      rd f003 00 d8 0
rom_rd_f007      rd f007 00 10 0
rom_rd_f00f      rd f00f 00 0c 0
rom_rd_f010      rd f010 00 f0 0
rom_rd_f01e      rd f01e 00 fa 0
rom_rd_f01f      rd f01f 00 5e 0
rom_rd_f020      rd f020 00 00 0
rom_wr_f003      wr f003 ff 00 2
rom_rerd_f003    rd f003 00 d8 0
rom_wr_ffff      wr ffff 55 00 2
dec_rd_0200      rd 0200 00 00 3
dec_rd_8000      rd 8000 00 00 3
dec_rd_e000      rd e000 00 00 3
dec_wr_8000      wr 8000 99 00 3
dec_rd_efff      rd efff 00 00 3
ram_keep_0011    rd 0011 00 3c 0

/* testbench/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic o_clk
);

initial begin
    o_clk = 1'b0;
end

// first rising edge at half a period
always begin
    #(PERIOD / 2);
    o_clk = ~o_clk;
end

endmodule

`default_nettype wire
